// ==== Makefile ====
# Verilator build and run for the HDC encoder

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := hdc_encoder_tb
FILELIST  := hdc_encoder.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== chunk_bundler.sv ====
`default_nettype none
`timescale 1ns/1ns

module chunk_bundler (
    input  wire hdc_pkg::hv_t       bound_hvs [0:hdc_pkg::FEATURE_COUNT-1],
    input  wire hdc_pkg::chunk_idx_t chunk_idx,
    output wire hdc_pkg::chunk_t    chunk_bits
);

    import hdc_pkg::*;

    chunk_t slices [0:FEATURE_COUNT-1];

    // ==============================
    // Chunk select
    // ==============================

    for (genvar f = 0; f < FEATURE_COUNT; f++) begin : g_slice
        assign slices[f] = bound_hvs[f][chunk_idx * CHUNK_DIM +: CHUNK_DIM];
    end

    // ==============================
    // Per-bit majority
    // ==============================

    // Gather one bit position across all features, then vote
    for (genvar b = 0; b < CHUNK_DIM; b++) begin : g_bit
        logic [FEATURE_COUNT-1:0] column;

        for (genvar f = 0; f < FEATURE_COUNT; f++) begin : g_col
            assign column[f] = slices[f][b];
        end

        assign chunk_bits[b] = ($countones(column) >= MAJORITY_MIN);
    end

endmodule

`default_nettype wire

// ==== encode_control.sv ====
`default_nettype none
`timescale 1ns/1ns

module encode_control (
    input  wire                 clk,
    input  wire                 nrst,
    input  wire                 en,
    input  wire                 start_encoding,
    output wire                 load_features,
    output wire                 chunk_write,
    output hdc_pkg::chunk_idx_t chunk_idx,
    output wire                 encoding_done
);

    import hdc_pkg::*;

    encode_state_t state;
    chunk_idx_t    chunk_cnt;
    logic          done_q;

    // ==============================
    // Strobes
    // ==============================

    assign load_features = (state == IDLE) && start_encoding && en;
    assign chunk_write   = (state == BUNDLE) && en;
    assign chunk_idx     = chunk_cnt;
    assign encoding_done = done_q;

    // ==============================
    // State and chunk counter
    // ==============================

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= IDLE;
            chunk_cnt <= '0;
            done_q    <= 1'b0;
        end else if (en) begin
            done_q <= (state == DONE);      // Pulse follows the DONE cycle
            case (state)
                IDLE: begin
                    if (start_encoding) begin
                        state     <= BUNDLE;
                        chunk_cnt <= '0;
                    end
                end
                BUNDLE: begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (chunk_cnt == chunk_idx_t'(CHUNK_COUNT - 1)) begin
                        state <= DONE;      // Last chunk written on this edge
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Checks
    // ==============================

    // No write follows the last chunk of an encoding
    a_chunk_in_range: assert property (
        @(posedge clk) disable iff (!nrst)
        (chunk_write && int'(chunk_idx) == CHUNK_COUNT - 1) |=> !chunk_write
    ) else $error("chunk write after the last chunk index");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!nrst)
        (encoding_done && en) |=> !encoding_done
    ) else $error("encoding_done longer than one enabled cycle");

endmodule

`default_nettype wire

// ==== feature_binder.sv ====
`default_nettype none
`timescale 1ns/1ns

module feature_binder (
    input  wire          clk,
    input  wire          nrst,
    input  wire          load_features,
    input  wire hdc_pkg::hv_t level_hvs [0:hdc_pkg::FEATURE_COUNT-1],
    output hdc_pkg::hv_t bound_hvs [0:hdc_pkg::FEATURE_COUNT-1]
);

    import hdc_pkg::*;

    hv_t rotated [0:FEATURE_COUNT-1];

    // Rotate left by the feature's shift
    for (genvar f = 0; f < FEATURE_COUNT; f++) begin : g_rotate
        assign rotated[f] = (level_hvs[f] << FEATURE_SHIFTS[f])
                          | (level_hvs[f] >> (HV_DIM - FEATURE_SHIFTS[f]));
    end

    // Latched copies feed the bundler for the whole encoding
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int f = 0; f < FEATURE_COUNT; f++) begin
                bound_hvs[f] <= '0;
            end
        end else if (load_features) begin
            bound_hvs <= rotated;
        end
    end

    // Bound vectors stay fixed while the inputs move on after the start edge
    for (genvar f = 0; f < FEATURE_COUNT; f++) begin : g_check
        a_bound_stable: assert property (
            @(posedge clk) disable iff (!nrst)
            !load_features |=> $stable(bound_hvs[f])
        ) else $error("bound_hvs[%0d] changed without load_features", f);
    end

endmodule

`default_nettype wire

// ==== hdc_encoder.f ====
hdc_pkg.sv
feature_binder.sv
encode_control.sv
chunk_bundler.sv
hv_assembler.sv
hdc_encoder.sv
hdc_encoder_tb.sv

// ==== hdc_encoder.sv ====
`default_nettype none
`timescale 1ns/1ns

module hdc_encoder (
    input  wire                clk,
    input  wire                nrst,
    input  wire                en,
    input  wire                start_encoding,
    input  wire hdc_pkg::hv_t  level_hvs [0:hdc_pkg::FEATURE_COUNT-1],
    output wire                encoding_done,
    output wire hdc_pkg::hv_t  encoded_hv
);

    import hdc_pkg::*;

    wire        load_features;
    wire        chunk_write;
    chunk_idx_t chunk_idx;
    chunk_t     chunk_bits;
    hv_t        bound_hvs [0:FEATURE_COUNT-1];

    // ==============================
    // Sequencing
    // ==============================

    encode_control i_encode_control (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .start_encoding (start_encoding),
        .load_features  (load_features),
        .chunk_write    (chunk_write),
        .chunk_idx      (chunk_idx),
        .encoding_done  (encoding_done)
    );

    // ==============================
    // Datapath
    // ==============================

    feature_binder i_feature_binder (
        .clk           (clk),
        .nrst          (nrst),
        .load_features (load_features),
        .level_hvs     (level_hvs),
        .bound_hvs     (bound_hvs)
    );

    chunk_bundler i_chunk_bundler (
        .bound_hvs  (bound_hvs),
        .chunk_idx  (chunk_idx),
        .chunk_bits (chunk_bits)
    );

    hv_assembler i_hv_assembler (
        .clk         (clk),
        .nrst        (nrst),
        .chunk_write (chunk_write),
        .chunk_idx   (chunk_idx),
        .chunk_bits  (chunk_bits),
        .encoded_hv  (encoded_hv)
    );

endmodule

`default_nettype wire

// ==== hdc_encoder_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module hdc_encoder_tb;

    import hdc_pkg::*;

    localparam int row_count      = 12;
    localparam int directed_rows  = 7;
    localparam int max_stall      = 3;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles =
        row_count * (CHUNK_COUNT + 1 + max_stall + 10) + reset_cycles;

    // Rotation amount per feature
    localparam int rot_table [0:FEATURE_COUNT-1] = '{0, 7, 13, 29, 42};

    logic clk;
    logic nrst;
    logic en;
    logic start_encoding;
    hv_t  level_hvs [0:FEATURE_COUNT-1];
    logic encoding_done;
    hv_t  encoded_hv;

    // ==============================
    // Stimulus table
    // ==============================

    hv_t row_levels   [0:row_count-1][0:FEATURE_COUNT-1];
    int  row_stall    [0:row_count-1];
    bit  row_spurious [0:row_count-1];
    bit  row_checked  [0:row_count-1];     // Directed rows carry a known answer
    hv_t row_expect   [0:row_count-1];

    int          cyc = 0;
    int          error_count;
    int          rows_failed;
    hv_t         prev_result;
    int unsigned seed_val;

    hdc_encoder i_hdc_encoder (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .start_encoding (start_encoding),
        .level_hvs      (level_hvs),
        .encoding_done  (encoding_done),
        .encoded_hv     (encoded_hv)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        while (cyc < timeout_cycles) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Test FAILED");
        $finish;
    end

    // ==============================
    // Reference model
    // ==============================

    // Bound bit j comes from level bit (j - shift) mod HV_DIM, then a strict majority vote
    function automatic hv_t model_encode(input int r);
        hv_t result;
        int  ones;
        int  src;
        result = '0;
        for (int j = 0; j < HV_DIM; j++) begin
            ones = 0;
            for (int f = 0; f < FEATURE_COUNT; f++) begin
                src = (j - rot_table[f] + HV_DIM) % HV_DIM;
                if (row_levels[r][f][src]) ones++;
            end
            result[j] = (2 * ones > FEATURE_COUNT);
        end
        return result;
    endfunction

    task automatic fill_table();
        int unsigned rnd;
        for (int r = 0; r < row_count; r++) begin
            for (int f = 0; f < FEATURE_COUNT; f++) begin
                row_levels[r][f] = '0;
            end
            row_stall[r]    = 0;
            row_spurious[r] = 1'b0;
            row_checked[r]  = 1'b0;
            row_expect[r]   = '0;
        end
        row_checked[0] = 1'b1;                  // All zeros
        for (int f = 0; f < FEATURE_COUNT; f++) begin
            row_levels[1][f] = '1;
        end
        row_checked[1] = 1'b1;
        row_expect[1]  = '1;
        // A single feature set loses the vote
        row_levels[2][0] = '1;
        row_stall[2]     = 1;
        row_checked[2]   = 1'b1;
        row_levels[3][1] = '1;
        row_levels[3][2] = '1;
        row_levels[3][4] = '1;
        row_spurious[3]  = 1'b1;
        row_checked[3]   = 1'b1;
        row_expect[3]    = '1;
        // Odd shifts flip the alternating phase
        for (int f = 0; f < FEATURE_COUNT; f++) begin
            row_levels[4][f] = 64'hAAAA_AAAA_AAAA_AAAA;
        end
        row_stall[4]   = 2;
        row_checked[4] = 1'b1;
        row_expect[4]  = 64'h5555_5555_5555_5555;
        // Three single bits that all land on bit 42
        row_levels[5][0] = 64'h0000_0400_0000_0000;
        row_levels[5][1] = 64'h0000_0008_0000_0000;
        row_levels[5][2] = 64'h0000_0000_2000_0000;
        row_checked[5]   = 1'b1;
        row_expect[5]    = 64'h0000_0400_0000_0000;
        // Wrap-around onto bit 3
        row_levels[6][2] = 64'h0040_0000_0000_0000;
        row_levels[6][3] = 64'h0000_0040_0000_0000;
        row_levels[6][4] = 64'h0000_0000_0200_0000;
        row_stall[6]     = 3;
        row_spurious[6]  = 1'b1;
        row_checked[6]   = 1'b1;
        row_expect[6]    = 64'h0000_0000_0000_0008;
        for (int r = directed_rows; r < row_count; r++) begin
            for (int f = 0; f < FEATURE_COUNT; f++) begin
                row_levels[r][f] = {$urandom, $urandom};
            end
            rnd             = $urandom;
            row_stall[r]    = int'(rnd % (max_stall + 1));
            row_spurious[r] = rnd[8];
        end
    endtask

    // ==============================
    // Row sequence
    // ==============================

    task automatic apply_row(input int r);
        int  errs_before;
        int  rel;
        int  done_rel;
        int  want_rel;
        int  wait_limit;
        hv_t expected;

        errs_before = error_count;
        expected    = model_encode(r);
        want_rel    = CHUNK_COUNT + 1 + row_stall[r];
        wait_limit  = want_rel + 4;

        @(posedge clk);
        for (int f = 0; f < FEATURE_COUNT; f++) begin
            level_hvs[f] <= row_levels[r][f];
        end
        start_encoding <= 1'b1;
        en             <= 1'b1;

        @(posedge clk);                         // Start edge
        start_encoding <= 1'b0;
        for (int f = 0; f < FEATURE_COUNT; f++) begin
            level_hvs[f] <= {$urandom, $urandom};   // Binder must already hold its copy
        end

        @(negedge clk);
        if (encoded_hv !== prev_result) begin
            $display("ERR encoded_hv got %h expected %h at start", encoded_hv, prev_result);
            error_count++;
        end
        if (encoding_done !== 1'b0) begin
            $display("ERR encoding_done got %h expected %h at start", encoding_done, 1'b0);
            error_count++;
        end

        rel      = 0;
        done_rel = -1;
        while (done_rel < 0 && rel < wait_limit) begin
            @(posedge clk);
            rel++;
            en             <= !(rel >= 2 && rel < 2 + row_stall[r]);
            start_encoding <= row_spurious[r] && (rel == 1 || rel == 2);
            @(negedge clk);
            if (encoding_done) done_rel = rel;
        end

        if (done_rel < 0) begin
            $display("Row %0d: encoding_done did not rise within %0d cycles of the start edge",
                     r, wait_limit);
            error_count++;
        end else begin
            if (done_rel != want_rel) begin
                $display("Row %0d: encoding_done rose %0d edges after start, expected %0d",
                         r, done_rel, want_rel);
                error_count++;
            end
            if (encoded_hv !== expected) begin
                $display("ERR encoded_hv got %h expected %h", encoded_hv, expected);
                error_count++;
            end
            @(posedge clk);
            en             <= 1'b1;
            start_encoding <= 1'b0;
            @(negedge clk);
            if (encoding_done !== 1'b0) begin
                $display("ERR encoding_done got %h expected %h after pulse",
                         encoding_done, 1'b0);
                error_count++;
            end
            @(posedge clk);
            @(negedge clk);
            if (encoded_hv !== expected) begin
                $display("ERR encoded_hv got %h expected %h while idle", encoded_hv, expected);
                error_count++;
            end
        end

        prev_result = expected;
        if (error_count != errs_before) rows_failed++;
        $display("Row %0d (stall %0d, spurious start %0d): %s", r, row_stall[r],
                 row_spurious[r], (error_count == errs_before) ? "pass" : "fail");
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int errs_before;

        nrst           <= 1'b0;
        en             <= 1'b0;
        start_encoding <= 1'b0;
        for (int f = 0; f < FEATURE_COUNT; f++) begin
            level_hvs[f] <= '0;
        end

        seed_val    = $urandom(42);
        error_count = 0;
        rows_failed = 0;
        prev_result = '0;
        fill_table();

        // Hand values and model must agree
        for (int r = 0; r < directed_rows; r++) begin
            if (row_checked[r] && model_encode(r) !== row_expect[r]) begin
                $display("Row %0d: reference model gives %h but the table holds %h",
                         r, model_encode(r), row_expect[r]);
                error_count++;
            end
        end

        repeat (reset_cycles) @(posedge clk);
        nrst <= 1'b1;
        en   <= 1'b1;

        @(negedge clk);
        errs_before = error_count;
        if (encoding_done !== 1'b0) begin
            $display("ERR encoding_done got %h expected %h after reset", encoding_done, 1'b0);
            error_count++;
        end
        if (encoded_hv !== '0) begin
            $display("ERR encoded_hv got %h expected %h after reset", encoded_hv, 64'h0);
            error_count++;
        end
        $display("Reset check: %s", (error_count == errs_before) ? "pass" : "fail");

        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end

        $display("Rows run: %0d, rows failed: %0d, errors: %0d",
                 row_count, rows_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdc_pkg.sv ====
`default_nettype none

package hdc_pkg;

    // ==============================
    // Sizes
    // ==============================

    localparam int HV_DIM        = 64;                      // Bits per hypervector
    localparam int FEATURE_COUNT = 5;                       // Odd so the vote never ties
    localparam int CHUNK_DIM     = 16;                      // Bits bundled per cycle
    localparam int CHUNK_COUNT   = HV_DIM / CHUNK_DIM;
    localparam int MAJORITY_MIN  = (FEATURE_COUNT + 1) / 2; // Ones needed for a bundled one

    // ==============================
    // Vector types
    // ==============================

    typedef logic [HV_DIM-1:0]                hv_t;
    typedef logic [CHUNK_DIM-1:0]             chunk_t;
    typedef logic [$clog2(CHUNK_COUNT)-1:0]   chunk_idx_t;
    typedef logic [$clog2(HV_DIM)-1:0]        shift_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        BUNDLE,
        DONE
    } encode_state_t;

    // ==============================
    // Binding
    // ==============================

    // Circular rotation per feature
    // Bit j of a bound vector takes bit (j - shift) mod HV_DIM of its level vector
    localparam shift_t FEATURE_SHIFTS [0:FEATURE_COUNT-1] = '{
        6'd0,
        6'd7,
        6'd13,
        6'd29,
        6'd42
    };

endpackage

`default_nettype wire

// ==== hv_assembler.sv ====
`default_nettype none
`timescale 1ns/1ns

module hv_assembler (
    input  wire                      clk,
    input  wire                      nrst,
    input  wire                      chunk_write,
    input  wire hdc_pkg::chunk_idx_t chunk_idx,
    input  wire hdc_pkg::chunk_t     chunk_bits,
    output hdc_pkg::hv_t             encoded_hv
);

    import hdc_pkg::*;

    // Chunk demux into the output register
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            encoded_hv <= '0;
        end else if (chunk_write) begin
            encoded_hv[chunk_idx * CHUNK_DIM +: CHUNK_DIM] <= chunk_bits;
        end
    end

    a_idx_known: assert property (
        @(posedge clk) disable iff (!nrst)
        chunk_write |-> !$isunknown(chunk_idx)
    ) else $error("chunk_write with unknown chunk_idx");

endmodule

`default_nettype wire
